// ==== verilog.f ====
design/timer_pkg.sv
design/phase_gen.sv
design/scaler_ring.sv
design/time_pulse_seq.sv
design/restart_control.sv
design/agc_timer.sv
bench/tb_agc_timer.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_agc_timer
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Regression passed

.PHONY: sim clean

sim:
	rm -f $(LOG)
	$(VERILATOR) --binary --timing --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/tb_agc_timer.sv ====
`timescale 1ns/100ps

module tb_agc_timer;
    import timer_pkg::*;

    localparam int          NUM_TP        = DEFAULT_TIME_PULSES;
    localparam int          NUM_ROWS      = 11;
    localparam int          PHASE_TIMEOUT = 8;
    localparam logic [31:0] LFSR_TAPS     = 32'h80200003;

    logic              sim_clk;
    logic              rst_n;
    logic              sby;
    logic              alga;
    logic              mstrtp;
    logic              strt1;
    logic              strt2;
    logic              mstp;
    phase_t            phase;
    logic              rt;
    logic              wt;
    logic              ct;
    logic [NUM_TP-1:0] time_pulse;
    scaler_t           scaler;
    logic              sb0;
    logic              sb1;
    logic              sb2;
    logic              sb4;
    logic              gojam;
    logic              stop;

    // Reference model state
    logic    m_running;
    logic    m_slot_odd;
    logic    m_stopa;
    logic    m_mstp_hold;
    int      m_phase;
    int      m_tp;
    int      m_slots;
    scaler_t m_scaler;

    scaler_t     ring_hist [10];
    logic [31:0] lfsr_state;

    // Stimulus table, one entry per row
    logic [5:0] row_req   [NUM_ROWS];
    int         row_slots [NUM_ROWS];
    int         row_tp    [NUM_ROWS];
    logic       row_gojam [NUM_ROWS];
    logic       row_stop  [NUM_ROWS];

    agc_timer #(.NUM_TIME_PULSES(NUM_TP)) DUT (.*);

    initial begin
        sim_clk = 1'b0;
        forever #2 sim_clk = ~sim_clk;
    end

    // Pulse numbers run 1 to NUM_TP and slot parity is that of the following slot
    always @(posedge sim_clk) begin : ref_model
        logic slot_end;
        logic jam;
        logic halt;
        int   nxt;
        if (!rst_n) begin
            m_running   = 1'b0;
            m_phase     = 0;
            m_slot_odd  = 1'b1;
            m_tp        = NUM_TP;
            m_scaler    = '0;
            m_stopa     = 1'b0;
            m_mstp_hold = 1'b0;
            m_slots     = 0;
        end else begin
            slot_end = m_running && (m_phase == 3);
            jam      = m_stopa | strt2;
            halt     = m_stopa | m_mstp_hold;
            if (slot_end) begin
                // Latches see the pulse of the slot that is ending
                if (!m_slot_odd) begin
                    if (sby | alga | mstrtp | strt1 | strt2) begin
                        m_stopa = 1'b1;
                    end else if (m_tp == NUM_TP) begin
                        m_stopa = 1'b0;
                    end
                    if (m_tp == NUM_TP) begin
                        m_mstp_hold = mstp;
                    end
                end
                nxt = (m_tp % NUM_TP) + 1;
                if (jam) begin
                    m_tp = NUM_TP;
                end else if (!(m_slot_odd && halt) && ((nxt % 2 == 1) == m_slot_odd)) begin
                    m_tp = nxt;
                end
                m_scaler   = {m_scaler[SCALER_STAGES-2:0], ~m_scaler[SCALER_STAGES-1]};
                m_slot_odd = ~m_slot_odd;
                m_slots    = m_slots + 1;
            end
            if (m_running) begin
                m_phase = (m_phase + 1) % 4;
            end
            m_running = 1'b1;
        end
    end

    task automatic check_val(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("Regression failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_cycle();
        scaler_t s;
        int      idx;
        s = m_scaler;
        check_val(32'(phase), m_phase, "phase");
        if (m_running && m_phase != 3) begin
            check_val(32'(rt) + 32'(wt) + 32'(ct), 1, "single phase strobe");
        end
        check_val(32'(rt), 32'(m_running && m_phase == 0), "rt");
        check_val(32'(wt), 32'(m_running && m_phase == 1), "wt");
        check_val(32'(ct), 32'(m_running && m_phase == 2), "ct");
        // T01 only ever shows in an odd slot
        if (time_pulse[0]) begin
            check_val(32'(!m_slot_odd), 1, "T01 slot parity");
        end
        check_val(32'(time_pulse), 32'(1) << (m_tp - 1), "time_pulse");
        // Johnson ring of five stages repeats every ten slots
        if (m_running && m_phase == 0) begin
            idx = m_slots % 10;
            if (m_slots >= 10) begin
                check_val(32'(scaler), 32'(ring_hist[idx]), "scaler ten slots back");
            end
            ring_hist[idx] = scaler;
        end
        check_val(32'(scaler), 32'(m_scaler), "scaler");
        check_val(32'(sb0), 32'(s[1] && !s[4]), "sb0");
        check_val(32'(sb1), 32'(s[2] && s[4]), "sb1");
        check_val(32'(sb2), 32'(s[4] && !s[1]), "sb2");
        check_val(32'(sb4), 32'(s[1] && !s[3]), "sb4");
        check_val(32'(gojam), 32'(m_stopa | strt2), "gojam");
        check_val(32'(stop), 32'(m_stopa | m_mstp_hold), "stop");
    endtask

    task automatic tick();
        @(negedge sim_clk);
        check_cycle();
    endtask

    task automatic wait_phase(input phase_t target);
        int waited;
        waited = 0;
        while (phase !== target) begin
            if (waited >= PHASE_TIMEOUT) begin
                $display("Timed out after %0d cycles waiting for phase %s", waited, target.name());
                $display("Regression failed");
                $fatal(1, "phase wait timed out");
            end
            tick();
            waited = waited + 1;
        end
    endtask

    task automatic run_slots(input int count);
        repeat (count) begin
            tick();
            wait_phase(PH_RT);
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic set_row(input int idx, input logic [5:0] req, input int slots,
                           input int tp, input logic gj, input logic st);
        row_req[idx]   = req;
        row_slots[idx] = slots;
        row_tp[idx]    = tp;
        row_gojam[idx] = gj;
        row_stop[idx]  = st;
    endtask

    initial begin : stimulus
        logic [31:0] extra;
        rst_n      = 1'b0;
        {sby, alga, mstrtp, strt1, strt2, mstp} = 6'b000000;
        lfsr_state = 32'he38f;
        // req is {sby, alga, mstrtp, strt1, strt2, mstp}, then slots, pulse, gojam, stop
        set_row(0,  6'b000000, 13, 1,  1'b0, 1'b0);
        set_row(1,  6'b100000, 4,  12, 1'b1, 1'b1);
        set_row(2,  6'b000000, 13, 12, 1'b0, 1'b0);
        set_row(3,  6'b000010, 2,  12, 1'b1, 1'b1);
        set_row(4,  6'b000000, 3,  1,  1'b0, 1'b0);
        set_row(5,  6'b010001, 4,  12, 1'b1, 1'b1);
        set_row(6,  6'b000001, 5,  12, 1'b0, 1'b1);
        set_row(7,  6'b000000, 4,  2,  1'b0, 1'b0);
        set_row(8,  6'b001000, 3,  12, 1'b1, 1'b1);
        set_row(9,  6'b000100, 2,  12, 1'b1, 1'b1);
        set_row(10, 6'b000000, 14, 1,  1'b0, 1'b0);
        repeat (10) @(negedge sim_clk);
        rst_n = 1'b1;
        tick();
        wait_phase(PH_RT);
        for (int r = 0; r < NUM_ROWS; r++) begin
            {sby, alga, mstrtp, strt1, strt2, mstp} = row_req[r];
            // strt2 reaches gojam before any clock edge
            #1;
            check_val(32'(gojam), 32'(m_stopa | strt2), $sformatf("row %0d early gojam", r));
            run_slots(row_slots[r]);
            check_val(32'(time_pulse), 32'(1) << (row_tp[r] - 1),
                      $sformatf("row %0d time_pulse", r));
            check_val(32'(gojam), 32'(row_gojam[r]), $sformatf("row %0d gojam", r));
            check_val(32'(stop), 32'(row_stop[r]), $sformatf("row %0d stop", r));
            // Whole pulse cycles of idle leave the row's end state unchanged
            draw_bits(2, extra);
            run_slots(12 * int'(extra));
        end
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== design/agc_timer.sv ====
`timescale 1ns/100ps

module agc_timer #(
    parameter int NUM_TIME_PULSES = timer_pkg::DEFAULT_TIME_PULSES
) (
    input  logic                       sim_clk,
    input  logic                       rst_n,
    input  logic                       sby,
    input  logic                       alga,
    input  logic                       mstrtp,
    input  logic                       strt1,
    input  logic                       strt2,
    input  logic                       mstp,
    output timer_pkg::phase_t          phase,
    output logic                       rt,
    output logic                       wt,
    output logic                       ct,
    output logic [NUM_TIME_PULSES-1:0] time_pulse,
    output timer_pkg::scaler_t         scaler,
    output logic                       sb0,
    output logic                       sb1,
    output logic                       sb2,
    output logic                       sb4,
    output logic                       gojam,
    output logic                       stop
);

    logic slot_step;
    logic slot_odd;

    // Phase counter and slot parity, shared by all other blocks
    phase_gen u_phase_gen (
        .sim_clk   (sim_clk),
        .rst_n     (rst_n),
        .phase     (phase),
        .rt        (rt),
        .wt        (wt),
        .ct        (ct),
        .slot_step (slot_step),
        .slot_odd  (slot_odd)
    );

    time_pulse_seq #(
        .NUM_TIME_PULSES (NUM_TIME_PULSES)
    ) u_time_pulse_seq (
        .sim_clk    (sim_clk),
        .rst_n      (rst_n),
        .slot_step  (slot_step),
        .slot_odd   (slot_odd),
        .stop       (stop),
        .gojam      (gojam),
        .time_pulse (time_pulse)
    );

    // Free running, not affected by stop or gojam
    scaler_ring u_scaler_ring (
        .sim_clk   (sim_clk),
        .rst_n     (rst_n),
        .slot_step (slot_step),
        .scaler    (scaler),
        .sb0       (sb0),
        .sb1       (sb1),
        .sb2       (sb2),
        .sb4       (sb4)
    );

    restart_control #(
        .NUM_TIME_PULSES (NUM_TIME_PULSES)
    ) u_restart_control (
        .sim_clk    (sim_clk),
        .rst_n      (rst_n),
        .slot_step  (slot_step),
        .slot_odd   (slot_odd),
        .time_pulse (time_pulse),
        .sby        (sby),
        .alga       (alga),
        .mstrtp     (mstrtp),
        .strt1      (strt1),
        .strt2      (strt2),
        .mstp       (mstp),
        .gojam      (gojam),
        .stop       (stop)
    );

endmodule

// ==== design/restart_control.sv ====
`timescale 1ns/100ps

module restart_control #(
    parameter int NUM_TIME_PULSES = timer_pkg::DEFAULT_TIME_PULSES
) (
    input  logic                       sim_clk,
    input  logic                       rst_n,
    input  logic                       slot_step,
    input  logic                       slot_odd,
    input  logic [NUM_TIME_PULSES-1:0] time_pulse,
    input  logic                       sby,
    input  logic                       alga,
    input  logic                       mstrtp,
    input  logic                       strt1,
    input  logic                       strt2,
    input  logic                       mstp,
    output logic                       gojam,
    output logic                       stop
);

    logic go_req;
    logic last_pulse;
    logic even_start;
    logic stopa;
    logic mstp_hold;

    // Any restart source sets the stop latch
    assign go_req = sby | alga | mstrtp | strt1 | strt2;

    assign last_pulse = time_pulse[NUM_TIME_PULSES-1];

    // Sample point is the edge that opens an even slot
    assign even_start = slot_step & ~slot_odd;

    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            stopa     <= 1'b0;
            mstp_hold <= 1'b0;
        end else if (even_start) begin
            if (go_req) begin
                stopa <= 1'b1;
            end else if (last_pulse) begin
                stopa <= 1'b0;
            end
            // Manual stop is only taken at the end of the pulse cycle
            if (last_pulse) begin
                mstp_hold <= mstp;
            end
        end
    end

    // strt2 reaches gojam without waiting for a slot
    assign gojam = stopa | strt2;
    assign stop  = stopa | mstp_hold;

endmodule

// ==== design/time_pulse_seq.sv ====
`timescale 1ns/100ps

module time_pulse_seq #(
    parameter int NUM_TIME_PULSES = timer_pkg::DEFAULT_TIME_PULSES
) (
    input  logic                       sim_clk,
    input  logic                       rst_n,
    input  logic                       slot_step,
    input  logic                       slot_odd,
    input  logic                       stop,
    input  logic                       gojam,
    output logic [NUM_TIME_PULSES-1:0] time_pulse
);

    localparam logic [NUM_TIME_PULSES-1:0] LAST_PULSE =
        {1'b1, {(NUM_TIME_PULSES-1){1'b0}}};

    logic [NUM_TIME_PULSES-1:0] rotated;
    logic                       next_is_odd;
    logic                       hold_on_stop;
    logic                       may_advance;

    // Candidate next pulse; T12 wraps round to T01
    always_comb begin
        rotated     = {time_pulse[NUM_TIME_PULSES-2:0], time_pulse[NUM_TIME_PULSES-1]};
        next_is_odd = 1'b0;
        // Odd pulse numbers sit on even bit positions
        for (int i = 0; i < NUM_TIME_PULSES; i += 2) begin
            next_is_odd = next_is_odd | rotated[i];
        end
    end

    // Stop only freezes the sequence going into odd slots
    assign hold_on_stop = slot_odd & stop;

    // A pulse is entered only in a slot of matching parity
    assign may_advance = ~hold_on_stop & (next_is_odd == slot_odd);

    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            time_pulse <= LAST_PULSE;
        end else if (slot_step) begin
            if (gojam) begin
                time_pulse <= LAST_PULSE;
            end else if (may_advance) begin
                time_pulse <= rotated;
            end
        end
    end

endmodule

// ==== design/scaler_ring.sv ====
`timescale 1ns/100ps

module scaler_ring (
    input  logic               sim_clk,
    input  logic               rst_n,
    input  logic               slot_step,
    output timer_pkg::scaler_t scaler,
    output logic               sb0,
    output logic               sb1,
    output logic               sb2,
    output logic               sb4
);
    import timer_pkg::*;

    scaler_t scaler_next;

    // Johnson shift, P01 takes the inverse of the last stage
    assign scaler_next = {scaler[SCALER_STAGES-2:0], ~scaler[SCALER_STAGES-1]};

    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            scaler <= '0;
        end else if (slot_step) begin
            scaler <= scaler_next;
        end
    end

    // Stage names as on the schematic
    logic p02;
    logic p03;
    logic p04;
    logic p05;

    assign p02 = scaler[1];
    assign p03 = scaler[2];
    assign p04 = scaler[3];
    assign p05 = scaler[4];

    // Each strobe picks out fixed points of the ten slot period
    assign sb0 = p02 & ~p05;
    assign sb1 = p03 & p05;
    assign sb2 = p05 & ~p02;
    assign sb4 = p02 & ~p04;

endmodule

// ==== design/phase_gen.sv ====
`timescale 1ns/100ps

module phase_gen (
    input  logic              sim_clk,
    input  logic              rst_n,
    output timer_pkg::phase_t phase,
    output logic              rt,
    output logic              wt,
    output logic              ct,
    output logic              slot_step,
    output logic              slot_odd
);
    import timer_pkg::*;

    phase_t phase_next;
    logic   running;

    // Phase sequence RT, WT, CT, PHS4
    always_comb begin
        case (phase)
            PH_RT:   phase_next = PH_WT;
            PH_WT:   phase_next = PH_CT;
            PH_CT:   phase_next = PH_PHS4;
            default: phase_next = PH_RT;
        endcase
    end

    // running holds phase in RT for one extra cycle after reset,
    // so slot 0 begins with a full RT cycle and its strobe
    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            running  <= 1'b0;
            phase    <= PH_RT;
            slot_odd <= 1'b1;
        end else begin
            running <= 1'b1;
            if (running) begin
                phase <= phase_next;
            end
            // Parity of the slot that follows, flips as each slot ends
            if (slot_step) begin
                slot_odd <= ~slot_odd;
            end
        end
    end

    assign rt        = running && (phase == PH_RT);
    assign wt        = running && (phase == PH_WT);
    assign ct        = running && (phase == PH_CT);
    assign slot_step = running && (phase == PH_PHS4);

endmodule

// ==== design/timer_pkg.sv ====
package timer_pkg;

    // One slot is four clock cycles, in this order
    typedef enum logic [1:0] {
        PH_RT   = 2'd0,
        PH_WT   = 2'd1,
        PH_CT   = 2'd2,
        PH_PHS4 = 2'd3
    } phase_t;

    // T01 through T12; any even count of 4 or more keeps the slot parity rule
    localparam int DEFAULT_TIME_PULSES = 12;

    // Scaler ring length, P01 through P05
    localparam int SCALER_STAGES = 5;

    // Bit 0 is P01, top bit is P05
    typedef logic [SCALER_STAGES-1:0] scaler_t;

endpackage
